//--- hw/inpkt_defs.svh
`ifndef INPKT_DEFS_SVH
`define INPKT_DEFS_SVH

// the one packet version accepted
`define INPKT_VERSION 8'd2
// legal types are 1 .. INPKT_MAX_TYPE
`define INPKT_MAX_TYPE 15
`define INPKT_TYPE_BITS 4
// data length counter width, longer packets are rejected
`define INPKT_LEN_BITS 17

`define INPKT_IN_DEPTH 16
`define INPKT_OUT_DEPTH 16

// host register word addresses
`define INPKT_REG_STATUS 2'd0
`define INPKT_REG_DATA 2'd1
`define INPKT_REG_COUNT 2'd2
`define INPKT_REG_CTRL 2'd3

`endif

//--- hw/inpkt_pkg.sv
`include "inpkt_defs.svh"

package inpkt_pkg;

	// one state per header byte, then checksum and data phases
	typedef enum logic [3:0] {
		ST_VERSION,
		ST_TYPE,
		ST_RES0A,
		ST_RES0B,
		ST_LEN0,
		ST_LEN1,
		ST_LEN2,
		ST_RES1,
		ST_ID0,
		ST_ID1,
		ST_HDR_SUM,
		ST_DATA,
		ST_DATA_SUM,
		ST_ERROR
	} pkt_state_t;

	// output beat, 29 bits
	typedef struct packed {
		logic [15:0] id;
		logic [`INPKT_TYPE_BITS-1:0] ptype;
		logic last;
		logic [7:0] data;
	} pkt_beat_t;

endpackage

//--- hw/inpkt_fifo.sv
`timescale 1ns/1ns

// first-word-fall-through queue, head entry always on pop_data
module inpkt_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic CLK,
	input logic reset,
	input logic flush,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic full
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic do_push;
	logic do_pop;

	// pointer wrap, also for depths that are not a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
		return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == CNT_BITS'(DEPTH));
	// push on full and pop on empty are ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// simultaneous push and pop leave the count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hw/inpkt_header.sv
`timescale 1ns/1ns
`include "inpkt_defs.svh"

// byte-serial packet parser
// header (10 bytes), header checksum, data, data checksum
module inpkt_header
	import inpkt_pkg::*;
#(
	parameter bit CHECK_SUM = 1'b1
) (
	input logic CLK,
	input logic reset,
	input logic restart,
	input logic [7:0] q_data,
	input logic q_empty,
	input logic out_full,
	output logic take,
	output logic beat_push,
	output pkt_beat_t beat,
	output logic pkt_good,
	output logic err_version,
	output logic err_type,
	output logic err_len,
	output logic err_checksum
);
	pkt_state_t state;
	logic [`INPKT_TYPE_BITS-1:0] ptype;
	logic [15:0] id;
	logic [15:0] len_lo;
	// data bytes left after the current one
	logic [`INPKT_LEN_BITS-1:0] remaining;
	// running sum and byte lane inside the current word
	logic [31:0] sum;
	logic [1:0] bidx;
	// checksum field assembly, the top byte comes straight from q_data
	logic [1:0] cidx;
	logic [23:0] recv;
	logic [31:0] sum_next;
	logic [31:0] sum_field;
	logic [23:0] len_in;
	logic sum_bad;
	logic chk_fail;
	logic last_byte;

	// stall on empty input, full output or a stopped parser
	assign take = !q_empty && !out_full && !restart && (state != ST_ERROR);
	assign last_byte = (remaining == '0);
	assign beat_push = take && (state == ST_DATA);
	assign beat = '{id: id, ptype: ptype, last: last_byte, data: q_data};

	// word sum is the same as each byte added at its lane offset
	assign sum_next = sum + ({24'b0, q_data} << {bidx, 3'b000});
	assign sum_field = {q_data, recv};
	assign sum_bad = CHECK_SUM && (sum_field != ~sum);
	assign len_in = {q_data, len_lo};

	always_ff @(posedge CLK) begin
		if (reset || restart) begin
			state <= ST_VERSION;
			sum <= '0;
			bidx <= '0;
			cidx <= '0;
			chk_fail <= 1'b0;
			pkt_good <= 1'b0;
			err_version <= 1'b0;
			err_type <= 1'b0;
			err_len <= 1'b0;
			err_checksum <= 1'b0;
		end else begin
			pkt_good <= 1'b0;
			chk_fail <= 1'b0;
			// mismatch found on the previous edge
			if (chk_fail)
				err_checksum <= 1'b1;

			if (take) begin
				// header and data bytes go into the sum, checksum fields do not
				if (state != ST_VERSION && state != ST_HDR_SUM && state != ST_DATA_SUM) begin
					sum <= sum_next;
					bidx <= bidx + 1'b1;
				end

				case (state)
					ST_VERSION: begin
						// zero bytes between packets are skipped
						if (q_data != 8'd0) begin
							sum <= {24'b0, q_data};
							bidx <= 2'd1;
							if (q_data != `INPKT_VERSION) begin
								err_version <= 1'b1;
								state <= ST_ERROR;
							end else begin
								state <= ST_TYPE;
							end
						end
					end
					ST_TYPE: begin
						if (q_data == 8'd0 || q_data > 8'(`INPKT_MAX_TYPE)) begin
							err_type <= 1'b1;
							state <= ST_ERROR;
						end else begin
							ptype <= q_data[`INPKT_TYPE_BITS-1:0];
							state <= ST_RES0A;
						end
					end
					ST_RES0A: state <= ST_RES0B;
					ST_RES0B: state <= ST_LEN0;
					ST_LEN0: begin
						len_lo[7:0] <= q_data;
						state <= ST_LEN1;
					end
					ST_LEN1: begin
						len_lo[15:8] <= q_data;
						state <= ST_LEN2;
					end
					ST_LEN2: begin
						remaining <= len_in[`INPKT_LEN_BITS-1:0] - 1'b1;
						// zero length or too wide for the counter
						if (len_in[23:`INPKT_LEN_BITS] != '0 ||
							len_in[`INPKT_LEN_BITS-1:0] == '0) begin
							err_len <= 1'b1;
							state <= ST_ERROR;
						end else begin
							state <= ST_RES1;
						end
					end
					ST_RES1: state <= ST_ID0;
					ST_ID0: begin
						id[7:0] <= q_data;
						state <= ST_ID1;
					end
					ST_ID1: begin
						id[15:8] <= q_data;
						state <= ST_HDR_SUM;
					end
					ST_DATA: begin
						if (last_byte)
							state <= ST_DATA_SUM;
						else
							remaining <= remaining - 1'b1;
					end
					ST_HDR_SUM, ST_DATA_SUM: begin
						if (cidx != 2'd3)
							recv[{cidx, 3'b000} +: 8] <= q_data;
						cidx <= cidx + 1'b1;
						if (cidx == 2'd3) begin
							// data sum starts fresh on a word boundary
							sum <= '0;
							bidx <= '0;
							if (sum_bad) begin
								chk_fail <= 1'b1;
								state <= ST_ERROR;
							end else if (state == ST_HDR_SUM) begin
								state <= ST_DATA;
							end else begin
								pkt_good <= 1'b1;
								state <= ST_VERSION;
							end
						end
					end
					default: state <= ST_ERROR;
				endcase
			end
		end
	end

endmodule

//--- hw/inpkt_host_wb.sv
`timescale 1ns/1ns
`include "inpkt_defs.svh"

// wishbone classic register slave
// status, beat read-out, good packet count, control
module inpkt_host_wb
	import inpkt_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_wdata,
	output logic [31:0] wb_rdata,
	output logic wb_ack,
	input pkt_beat_t beat,
	input logic beat_empty,
	output logic beat_pop,
	input logic in_full,
	input logic pkt_good,
	input logic err_version,
	input logic err_type,
	input logic err_len,
	input logic err_checksum,
	output logic restart
);
	logic access;
	logic [31:0] count;
	logic [31:0] status;
	logic [31:0] read_value;

	// new request, one per ack
	assign access = wb_cyc && wb_stb && !wb_ack;

	// beat leaves the queue at the edge that latches it into wb_rdata
	assign beat_pop = access && !wb_we && (wb_adr == `INPKT_REG_DATA) && !beat_empty;
	assign restart = access && wb_we && (wb_adr == `INPKT_REG_CTRL) && wb_wdata[0];

	assign status = {26'b0, in_full, !beat_empty,
		err_checksum, err_len, err_type, err_version};

	always_comb begin
		read_value = '0;
		case (wb_adr)
			`INPKT_REG_STATUS: read_value = status;
			`INPKT_REG_DATA: begin
				// bit 31 marks a valid beat, empty queue reads as zero
				if (!beat_empty)
					read_value = {1'b1, 2'b00, beat};
			end
			`INPKT_REG_COUNT: read_value = count;
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_ack <= 1'b0;
			wb_rdata <= '0;
			count <= '0;
		end else begin
			wb_ack <= access;
			if (access && !wb_we)
				wb_rdata <= read_value;
			// wraps, kept across restart
			if (pkt_good)
				count <= count + 1'b1;
		end
	end

endmodule

//--- hw/inpkt_top.sv
`timescale 1ns/1ns
`include "inpkt_defs.svh"

// byte input -> input queue -> parser -> beat queue -> host slave
module inpkt_top
	import inpkt_pkg::*;
#(
	parameter bit CHECK_SUM = 1'b1
) (
	input logic CLK,
	input logic reset,
	input logic [7:0] din,
	input logic wr_en,
	output logic full,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [31:0] wb_wdata,
	output logic [31:0] wb_rdata,
	output logic wb_ack
);
	logic [7:0] q_data;
	logic q_empty;
	logic take;
	logic out_full;
	logic beat_push;
	pkt_beat_t beat_in;
	pkt_beat_t beat_out;
	logic beat_empty;
	logic beat_pop;
	logic pkt_good;
	logic err_version;
	logic err_type;
	logic err_len;
	logic err_checksum;
	logic restart;

	// restart drops whatever is still waiting in the input queue
	inpkt_fifo #(.payload_t(logic [7:0]), .DEPTH(`INPKT_IN_DEPTH)) in_q (
		.CLK(CLK), .reset(reset), .flush(restart),
		.push(wr_en), .push_data(din),
		.pop(take), .pop_data(q_data),
		.empty(q_empty), .full(full)
	);

	inpkt_header #(.CHECK_SUM(CHECK_SUM)) parser (
		.CLK(CLK), .reset(reset), .restart(restart),
		.q_data(q_data), .q_empty(q_empty), .out_full(out_full),
		.take(take), .beat_push(beat_push), .beat(beat_in), .pkt_good(pkt_good),
		.err_version(err_version), .err_type(err_type),
		.err_len(err_len), .err_checksum(err_checksum)
	);

	// beats already parsed survive a restart
	inpkt_fifo #(.payload_t(pkt_beat_t), .DEPTH(`INPKT_OUT_DEPTH)) out_q (
		.CLK(CLK), .reset(reset), .flush(1'b0),
		.push(beat_push), .push_data(beat_in),
		.pop(beat_pop), .pop_data(beat_out),
		.empty(beat_empty), .full(out_full)
	);

	inpkt_host_wb host (
		.CLK(CLK), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.beat(beat_out), .beat_empty(beat_empty), .beat_pop(beat_pop),
		.in_full(full), .pkt_good(pkt_good),
		.err_version(err_version), .err_type(err_type),
		.err_len(err_len), .err_checksum(err_checksum),
		.restart(restart)
	);

endmodule

//--- tests/inpkt_assert.sv
`timescale 1ns/1ns

// protocol and queue checks, bound into inpkt_top
module inpkt_assert (
	input logic CLK,
	input logic reset,
	input logic wr_en,
	input logic full,
	input logic take,
	input logic wb_ack,
	input logic restart,
	input logic err_version,
	input logic err_type,
	input logic err_len,
	input logic err_checksum
);
	logic [3:0] errs;

	assign errs = {err_checksum, err_len, err_type, err_version};

	// ack is a one cycle pulse
	ack_pulse: assert property (@(posedge CLK) disable iff (reset) wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high longer than one cycle");

	// producer must hold off while the input queue is full
	in_push_full: assert property (@(posedge CLK) disable iff (reset) !(wr_en && full))
		else $error("write reached the full input queue");

	// a stopped parser takes no byte, so no beat follows an error
	take_no_error: assert property (@(posedge CLK) disable iff (reset)
		take |-> (errs == 4'b0))
		else $error("parser consumed a byte while an error flag was set");

	// no flag may drop unless restart was high
	sticky_errs: assert property (@(posedge CLK) disable iff (reset)
		!restart |=> ((errs & $past(errs)) == $past(errs)))
		else $error("error flag cleared without restart");

endmodule

//--- tests/inpkt_tb.sv
`timescale 1ns/1ns
`include "inpkt_defs.svh"

module inpkt_tb;
	logic CLK;
	logic reset;
	logic [7:0] din;
	logic wr_en;
	logic full;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic wb_ack;

	logic [31:0] seed;
	// bytes waiting to be sent, data of the packet being built
	logic [7:0] stream[$];
	logic [7:0] pkt_data[$];
	// expected DATA words in read order
	logic [31:0] exp_q[$];
	logic [31:0] exp_count;
	int mon_idx = 0;
	int mon_errors = 0;
	int errors;
	int err_mark;
	int tests_run;
	int tests_failed;

	inpkt_top #(.CHECK_SUM(1'b1)) dut (.*);

	bind inpkt_top inpkt_assert checks (
		.CLK(CLK), .reset(reset), .wr_en(wr_en), .full(full),
		.take(take), .wb_ack(wb_ack), .restart(restart),
		.err_version(err_version), .err_type(err_type),
		.err_len(err_len), .err_checksum(err_checksum)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = seed;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		seed = x;
		return x;
	endfunction

	// inverted sum of little-endian words, last word zero padded
	function automatic logic [31:0] word_checksum(input logic [7:0] bytes_in[$]);
		logic [31:0] sum;
		sum = '0;
		foreach (bytes_in[i])
			sum = sum + (32'(bytes_in[i]) << (8 * (i % 4)));
		return ~sum;
	endfunction

	function automatic void append_word(input logic [31:0] w);
		stream.push_back(w[7:0]);
		stream.push_back(w[15:8]);
		stream.push_back(w[23:16]);
		stream.push_back(w[31:24]);
	endfunction

	// zeros, header, header sum, random data, data sum
	function automatic void build_packet(input logic [7:0] ver, input logic [7:0] typ,
		input int len, input logic [15:0] id, input int zeros,
		input bit bad_hdr, input bit bad_data);
		logic [7:0] hdr_b[10];
		logic [7:0] hdr[$];
		logic [23:0] len24;
		logic [31:0] r;
		logic [31:0] hsum;
		logic [31:0] dsum;
		len24 = 24'(len);
		pkt_data.delete();
		repeat (zeros)
			stream.push_back(8'h00);
		hdr_b = '{ver, typ, 8'h00, 8'h00, len24[7:0], len24[15:8], len24[23:16],
			8'h00, id[7:0], id[15:8]};
		foreach (hdr_b[i])
			hdr.push_back(hdr_b[i]);
		for (int i = 0; i < len; i++) begin
			r = next_rand();
			pkt_data.push_back(r[7:0]);
		end
		hsum = word_checksum(hdr);
		dsum = word_checksum(pkt_data);
		// a flipped bit is enough to break either sum
		if (bad_hdr)
			hsum[9] = ~hsum[9];
		if (bad_data)
			dsum[20] = ~dsum[20];
		foreach (hdr[i])
			stream.push_back(hdr[i]);
		append_word(hsum);
		foreach (pkt_data[i])
			stream.push_back(pkt_data[i]);
		append_word(dsum);
	endfunction

	// reference: valid bit, id, type, last, data for every data byte
	function automatic void expected_beats(input logic [3:0] typ, input logic [15:0] id,
		input bit good);
		logic last;
		foreach (pkt_data[i]) begin
			last = (i == pkt_data.size() - 1);
			exp_q.push_back({1'b1, 2'b00, id, typ, last, pkt_data[i]});
		end
		if (good)
			exp_count = exp_count + 32'd1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// one wishbone access, then an idle cycle so the bus monitor sees a stable address
	task automatic wb_transfer(input logic we, input logic [1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdata = wdata;
		n = 0;
		do begin
			@(posedge CLK);
			#2;
			n++;
		end while (!wb_ack && n < 20);
		if (!wb_ack) begin
			errors++;
			$display("%0t: no wb_ack within 20 cycles", $time);
		end
		rdata = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(posedge CLK);
		#2;
	endtask

	// re-read until the masked value matches, then check it
	task automatic poll_reg(input string name, input logic [1:0] adr,
		input logic [31:0] mask, input logic [31:0] exp);
		logic [31:0] v;
		int n;
		n = 0;
		do begin
			wb_transfer(1'b0, adr, 32'h0, v);
			n++;
		end while ((v & mask) !== exp && n < 100);
		check_value(name, v & mask, exp);
	endtask

	task automatic clear_errors();
		logic [31:0] v;
		wb_transfer(1'b1, `INPKT_REG_CTRL, 32'h1, v);
		poll_reg("STATUS after clear", `INPKT_REG_STATUS, 32'hf, 32'h0);
	endtask

	task automatic send_bytes();
		int n;
		foreach (stream[i]) begin
			n = 0;
			// producer holds off while full
			while (full && n < 400) begin
				wr_en = 1'b0;
				@(posedge CLK);
				#2;
				n++;
			end
			if (full) begin
				errors++;
				$display("%0t: input queue stayed full, byte %0d never sent", $time, i);
				break;
			end
			wr_en = 1'b1;
			din = stream[i];
			@(posedge CLK);
			#2;
		end
		wr_en = 1'b0;
		stream.delete();
	endtask

	// reads DATA until count beats came back, the monitor compares them
	task automatic drain_beats(input int count, input bit hold_until_full);
		logic [31:0] v;
		int got;
		int tries;
		got = 0;
		tries = 0;
		if (hold_until_full) begin
			while (!full && tries < 500) begin
				@(posedge CLK);
				#2;
				tries++;
			end
			if (!full) begin
				errors++;
				$display("%0t: full never rose while the host was idle", $time);
			end
		end
		tries = 0;
		while (got < count && tries < count * 8 + 200) begin
			wb_transfer(1'b0, `INPKT_REG_DATA, 32'h0, v);
			if (v[31])
				got++;
			tries++;
		end
		if (got < count) begin
			errors++;
			$display("%0t: only %0d of %0d beats could be read", $time, got, count);
		end
	endtask

	task automatic stream_and_drain(input int beats, input bit hold_until_full);
		fork
			send_bytes();
			drain_beats(beats, hold_until_full);
		join
	endtask

	task automatic end_test(input string name);
		@(posedge CLK);
		#2;
		if (mon_idx != exp_q.size()) begin
			errors++;
			$display("%0d expected beats were never read", exp_q.size() - mon_idx);
		end
		tests_run++;
		if (errors + mon_errors != err_mark) begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end else begin
			$display("test %s: ok", name);
		end
		err_mark = errors + mon_errors;
	endtask

	// header errors stop the parser early, send only what fits in the input queue
	task automatic header_error_test(input string name, input logic [7:0] ver,
		input logic [7:0] typ, input int len, input int flag);
		build_packet(ver, typ, len, 16'h0a0b, 0, 1'b0, 1'b0);
		while (stream.size() > 12)
			void'(stream.pop_back());
		send_bytes();
		poll_reg("STATUS", `INPKT_REG_STATUS, 32'h1f, 32'h1 << flag);
		clear_errors();
		end_test(name);
	endtask

	// compares every valid beat read from DATA with the next expected one
	always @(negedge CLK) begin
		if (!reset && wb_ack && !wb_we && wb_adr == `INPKT_REG_DATA && wb_rdata[31]) begin
			if (mon_idx >= exp_q.size()) begin
				mon_errors++;
				$display("%0t: beat %h read from DATA but none was expected", $time, wb_rdata);
			end else begin
				assert (wb_rdata === exp_q[mon_idx]) else begin
					mon_errors++;
					$display("error at %0t ns: wb_rdata is %h, expected %h",
						$time, wb_rdata, exp_q[mon_idx]);
				end
				mon_idx++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [3:0] typ;
		int len;
		int total;
		din = 8'h00;
		wr_en = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_wdata = 32'h0;
		reset = 1'b1;
		seed = 32'h0588a480;
		exp_count = 32'h0;
		errors = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge CLK);
		#2;
		reset = 1'b0;

		// five random legal packets with zero fill between them
		total = 0;
		for (int p = 0; p < 5; p++) begin
			r = next_rand();
			len = 1 + int'(r[7:0]) % 40;
			typ = r[11:8] % 4'd15 + 4'd1;
			build_packet(`INPKT_VERSION, {4'b0, typ}, len, r[31:16], int'(r[13:12]), 1'b0, 1'b0);
			expected_beats(typ, r[31:16], 1'b1);
			total += len;
		end
		stream_and_drain(total, 1'b0);
		poll_reg("COUNT", `INPKT_REG_COUNT, 32'hffffffff, exp_count);
		end_test("random legal packets");

		// bad data sum still delivers beats, count stays
		build_packet(`INPKT_VERSION, 8'd3, 6, 16'h1234, 1, 1'b0, 1'b1);
		expected_beats(4'd3, 16'h1234, 1'b0);
		stream_and_drain(6, 1'b0);
		poll_reg("STATUS checksum bit", `INPKT_REG_STATUS, 32'h8, 32'h8);
		poll_reg("COUNT", `INPKT_REG_COUNT, 32'hffffffff, exp_count);
		clear_errors();
		build_packet(`INPKT_VERSION, 8'd7, 9, 16'hbeef, 2, 1'b0, 1'b0);
		expected_beats(4'd7, 16'hbeef, 1'b1);
		stream_and_drain(9, 1'b0);
		poll_reg("COUNT", `INPKT_REG_COUNT, 32'hffffffff, exp_count);
		end_test("data checksum error and recovery");

		header_error_test("bad version", 8'd5, 8'd1, 4, 0);
		header_error_test("type zero", `INPKT_VERSION, 8'd0, 4, 1);
		header_error_test("length zero", `INPKT_VERSION, 8'd2, 0, 2);

		// header sum error, parser stops before any data
		build_packet(`INPKT_VERSION, 8'd9, 3, 16'h4242, 0, 1'b1, 1'b0);
		send_bytes();
		poll_reg("STATUS", `INPKT_REG_STATUS, 32'h1f, 32'h8);
		clear_errors();
		end_test("header checksum error");

		// host idle until the input queue fills
		r = next_rand();
		build_packet(`INPKT_VERSION, 8'd15, 60, r[15:0], 1, 1'b0, 1'b0);
		expected_beats(4'd15, r[15:0], 1'b1);
		stream_and_drain(60, 1'b1);
		poll_reg("COUNT", `INPKT_REG_COUNT, 32'hffffffff, exp_count);
		end_test("back-pressure with 60 byte packet");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + mon_errors);
		if (errors + mon_errors == 0 && tests_failed == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+hw
hw/inpkt_pkg.sv
hw/inpkt_fifo.sv
hw/inpkt_header.sv
hw/inpkt_host_wb.sv
hw/inpkt_top.sv
tests/inpkt_assert.sv
tests/inpkt_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= inpkt_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
